// File: common/obj_job_if.sv
// One sprite job at a time; fields only need to hold on the start pulse
`timescale 1ns/10ps
`default_nettype none

interface obj_job_if import obj_pkg::*; ();

    logic      start;    // One-cycle pulse, only while busy is low
    logic      busy;     // Rises the cycle after start
    obj_xpos_t xpos;     // First column
    obj_ofs_t  offset;   // Row start word in the bank
    obj_bank_t bank;
    obj_prio_t prio;
    obj_pal_t  pal;
    obj_zoom_t hzoom;
    logic      hflip;

    modport scan (
        output start, xpos, offset, bank, prio, pal, hzoom, hflip,
        input  busy
    );

    modport draw (
        input  start, xpos, offset, bank, prio, pal, hzoom, hflip,
        output busy
    );

endinterface

`default_nettype wire

// File: common/obj_pkg.sv
// Shared sprite engine types assume a 16-entry table of four words and one fixed bank mapping
`default_nettype none

package obj_pkg;

    typedef logic [8:0]  obj_xpos_t;      // Line buffer column
    typedef logic [7:0]  obj_line_t;      // Video line
    typedef logic [15:0] obj_ofs_t;       // Word offset inside a bank
    typedef logic [3:0]  obj_bank_t;
    typedef logic [1:0]  obj_prio_t;
    typedef logic [5:0]  obj_pal_t;
    typedef logic [4:0]  obj_zoom_t;      // Horizontal zoom step
    typedef logic [3:0]  obj_pitch_t;     // ROM words per sprite row
    typedef logic [19:0] obj_rom_addr_t;  // Bank above offset
    typedef logic [15:0] obj_rom_data_t;  // Four 4-bit pixels
    typedef logic [11:0] obj_pxl_t;       // Priority, palette, index

    localparam int OBJ_ENTRIES   = 16;
    localparam int OBJ_WORDS     = 4;     // 16-bit words per entry
    localparam int OBJ_TBL_AW    = 6;     // Entry above word select
    localparam int OBJ_BUF_DEPTH = 512;

    localparam logic [3:0] OBJ_TRANSP = 4'd15;
    // Cleared buffer location
    localparam obj_pxl_t   OBJ_BLANK  = {2'd0, 6'd0, OBJ_TRANSP};

    // Word 0 holds top line low and bottom line high
    // Word 1 fields, xpos sits in bits 8..0
    localparam int OBJ_HFLIP_BIT = 9;
    localparam int OBJ_ZOOM_LSB  = 10;
    localparam int OBJ_EN_BIT    = 15;
    // Word 2 is the base offset
    // Word 3 fields, bank sits in bits 3..0
    localparam int OBJ_PRIO_LSB  = 4;
    localparam int OBJ_PAL_LSB   = 6;
    localparam int OBJ_PITCH_LSB = 12;

    // Table walk
    typedef enum logic [2:0] {
        IDLE,
        READ,
        CHECK,
        LAUNCH,
        WAIT,
        DONE
    } obj_scan_state_t;

endpackage

`default_nettype wire

// File: filelist.f
common/obj_pkg.sv
common/obj_job_if.sv
obj/obj_attr_regs.sv
obj/obj_scan.sv
obj/obj_draw.sv
obj/obj_linebuf.sv
hdl/obj_top.sv
tests/tb_obj.sv

// File: hdl/obj_top.sv
// ROM port has no burst support; one 16-bit word per request
`timescale 1ns/10ps
`default_nettype none

module obj_top import obj_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  host_we,
    input  wire logic [OBJ_TBL_AW-1:0] host_addr,
    input  wire logic [15:0]           host_data,
    input  wire logic                  hstart,
    input  wire obj_line_t             vline,
    output logic                       obj_cs,
    output obj_rom_addr_t              obj_addr,
    input  wire obj_rom_data_t         obj_data,
    input  wire logic                  obj_ok,
    input  wire obj_xpos_t             rd_addr,
    output obj_pxl_t                   rd_data
);

    logic [3:0]              tbl_idx;
    logic [OBJ_WORDS*16-1:0] tbl_entry;
    logic                    bf_we;
    obj_xpos_t               bf_addr;
    obj_pxl_t                bf_data;

    obj_job_if job ();   // Scanner to drawer

    obj_attr_regs u_attr (
        .clk       (clk),
        .rst       (rst),
        .host_we   (host_we),
        .host_addr (host_addr),
        .host_data (host_data),
        .tbl_idx   (tbl_idx),
        .tbl_entry (tbl_entry)
    );

    obj_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .hstart    (hstart),
        .vline     (vline),
        .tbl_entry (tbl_entry),
        .tbl_idx   (tbl_idx),
        .job       (job.scan)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .obj_ok   (obj_ok),
        .obj_data (obj_data),
        .obj_cs   (obj_cs),
        .obj_addr (obj_addr),
        .job      (job.draw),
        .bf_we    (bf_we),
        .bf_addr  (bf_addr),
        .bf_data  (bf_data)
    );

    obj_linebuf u_buf (
        .clk     (clk),
        .rst     (rst),
        .hstart  (hstart),
        .bf_we   (bf_we),
        .bf_addr (bf_addr),
        .bf_data (bf_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: obj/obj_attr_regs.sv
// Host writes land one cycle later; only the enable bits are cleared by reset
`timescale 1ns/10ps
`default_nettype none

module obj_attr_regs import obj_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    host_we,
    input  wire logic [OBJ_TBL_AW-1:0]   host_addr,
    input  wire logic [15:0]             host_data,
    input  wire logic [3:0]              tbl_idx,
    output logic      [OBJ_WORDS*16-1:0] tbl_entry
);

    logic [15:0]            words [OBJ_ENTRIES][OBJ_WORDS];  // Table body
    logic [OBJ_ENTRIES-1:0] en;                              // Enable bits, kept apart
    logic [3:0]             wr_ent;
    logic [1:0]             wr_word;

    assign wr_ent  = host_addr[OBJ_TBL_AW-1:2];
    assign wr_word = host_addr[1:0];

    always_ff @(posedge clk) begin
        if (host_we) words[wr_ent][wr_word] <= host_data;
    end

    // Sprites stay off after reset until the host enables them
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en <= '0;
        end else if (host_we && wr_word == 2'd1) begin
            en[wr_ent] <= host_data[OBJ_EN_BIT];
        end
    end

    // All four words captured together so the scanner never sees a torn entry
    always_ff @(posedge clk) begin
        tbl_entry <= {
            words[tbl_idx][3],
            words[tbl_idx][2],
            en[tbl_idx], words[tbl_idx][1][OBJ_EN_BIT-1:0],  // Live enable bit
            words[tbl_idx][0]
        };
    end

endmodule

`default_nettype wire

// File: obj/obj_draw.sv
// One ROM request in flight; a sprite runs until a word ends in index 15 or until hstart
`timescale 1ns/10ps
`default_nettype none

module obj_draw import obj_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          hstart,
    input  wire logic          obj_ok,
    input  wire obj_rom_data_t obj_data,
    output logic               obj_cs,
    output obj_rom_addr_t      obj_addr,
    obj_job_if.draw            job,
    output logic               bf_we,
    output obj_xpos_t          bf_addr,
    output obj_pxl_t           bf_data
);

    logic          draw;        // Unpacking the fetched word
    logic          stop;        // Set per request until obj_ok is seen low
    logic [1:0]    cnt;         // Pixel within the word
    obj_ofs_t      cur;         // Word being fetched
    obj_rom_data_t pxl_data;    // Shifts one pixel per draw cycle
    obj_xpos_t     col;
    logic [6:0]    hzcnt;       // Zoom accumulator
    logic [7:0]    hzsum;
    logic          hzov;        // Pixel dropped by zoom
    logic [3:0]    cur_pxl;
    logic          take;
    logic          word_end;
    obj_bank_t     bank_r;
    obj_prio_t     prio_r;
    obj_pal_t      pal_r;
    obj_zoom_t     zoom_r;
    logic          flip_r;

    // Flip takes the low nibble first
    assign cur_pxl  = flip_r ? pxl_data[3:0] : pxl_data[15:12];
    assign hzsum    = {1'b0, hzcnt} + {3'd0, zoom_r};
    assign hzov     = hzsum[7];
    assign take     = obj_cs && obj_ok && !stop && !draw;
    assign word_end = draw && cnt == 2'd3;

    assign obj_addr = {bank_r, cur};
    assign bf_we    = draw && !hzov && cur_pxl != OBJ_TRANSP;  // Skip holes and zoomed-out pixels
    assign bf_addr  = col;
    assign bf_data  = {prio_r, pal_r, cur_pxl};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            job.busy <= 1'b0;
            draw     <= 1'b0;
            obj_cs   <= 1'b0;
            stop     <= 1'b0;
            cnt      <= '0;
        end else if (hstart) begin
            job.busy <= 1'b0;       // Unfinished sprite is dropped
            draw     <= 1'b0;
            obj_cs   <= 1'b0;
        end else if (job.start) begin
            job.busy <= 1'b1;
            draw     <= 1'b0;
            obj_cs   <= 1'b1;       // First word at the row offset
            stop     <= 1'b1;
        end else begin
            if (!obj_ok) stop <= 1'b0;
            if (take) begin
                draw   <= 1'b1;
                cnt    <= '0;
                obj_cs <= 1'b0;
            end else if (draw) begin
                cnt <= cnt + 2'd1;
                if (word_end) begin
                    draw <= 1'b0;
                    if (cur_pxl == OBJ_TRANSP) begin
                        job.busy <= 1'b0;   // Sprite ends on this word
                    end else begin
                        obj_cs <= 1'b1;     // Next word
                        stop   <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (job.start) begin
            cur    <= job.offset;
            col    <= job.xpos;
            hzcnt  <= {job.hzoom, 2'd0};    // Zoom times 4
            zoom_r <= job.hzoom;
            flip_r <= job.hflip;
            bank_r <= job.bank;
            prio_r <= job.prio;
            pal_r  <= job.pal;
        end else begin
            if (take) pxl_data <= obj_data;
            if (draw) begin
                pxl_data <= flip_r ? pxl_data >> 4 : pxl_data << 4;
                hzcnt    <= hzsum[6:0];
                if (!hzov) col <= col + 9'd1;  // Wraps at 512
                if (word_end && cur_pxl != OBJ_TRANSP) begin
                    cur <= flip_r ? cur - 16'd1 : cur + 16'd1;  // Flip walks down
                end
            end
        end
    end

    addr_hold_a: assert property (@(posedge clk) disable iff (rst)
        obj_cs && !obj_ok |=> $stable(obj_addr));

    we_busy_a: assert property (@(posedge clk) disable iff (rst)
        bf_we |-> job.busy);

endmodule

`default_nettype wire

// File: obj/obj_linebuf.sv
// Contents are unknown until one full read pass has cleared each half
`timescale 1ns/10ps
`default_nettype none

module obj_linebuf import obj_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      hstart,
    input  wire logic      bf_we,
    input  wire obj_xpos_t bf_addr,
    input  wire obj_pxl_t  bf_data,
    input  wire obj_xpos_t rd_addr,
    output obj_pxl_t       rd_data
);

    logic wr_half;   // Half being drawn
    logic rd_half;   // Half behind rd_data

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_half <= 1'b0;
            rd_half <= 1'b1;
        end else begin
            if (hstart) wr_half <= ~wr_half;  // Swap halves each line
            rd_half <= ~wr_half;              // Follows the read one cycle late
        end
    end

    for (genvar h = 0; h < 2; h++) begin : g_half
        obj_pxl_t  mem [OBJ_BUF_DEPTH];
        obj_pxl_t  q;
        logic      drawing;
        logic      we;
        obj_xpos_t addr;
        obj_pxl_t  din;

        assign drawing = wr_half == 1'(h);
        // Read half clears the location it reads
        assign we      = drawing ? bf_we : 1'b1;
        assign addr    = drawing ? bf_addr : rd_addr;
        assign din     = drawing ? bf_data : OBJ_BLANK;

        always_ff @(posedge clk) begin
            if (we) mem[addr] <= din;
            q <= mem[rd_addr];    // Old value before the clear
        end
    end

    assign rd_data = rd_half ? g_half[1].q : g_half[0].q;

endmodule

`default_nettype wire

// File: obj/obj_scan.sv
// Walks all 16 entries once per line; hstart restarts the walk from any state
`timescale 1ns/10ps
`default_nettype none

module obj_scan import obj_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    hstart,
    input  wire obj_line_t               vline,
    input  wire logic [OBJ_WORDS*16-1:0] tbl_entry,
    output logic      [3:0]              tbl_idx,
    obj_job_if.scan                      job
);

    obj_scan_state_t state;
    obj_line_t       line;          // Line being prepared
    logic [15:0]     w0, w1, w2, w3;
    obj_line_t       top, bottom;
    obj_line_t       row;           // Line inside the sprite
    obj_pitch_t      pitch;
    obj_ofs_t        row_ofs;
    logic            hit;
    logic            last;

    assign w0 = tbl_entry[15:0];
    assign w1 = tbl_entry[31:16];
    assign w2 = tbl_entry[47:32];
    assign w3 = tbl_entry[63:48];

    assign top     = w0[7:0];
    assign bottom  = w0[15:8];
    assign pitch   = w3[OBJ_PITCH_LSB +: 4];
    assign row     = line - top;
    assign row_ofs = w2 + obj_ofs_t'(row) * obj_ofs_t'(pitch);  // Base plus row times pitch
    assign hit     = w1[OBJ_EN_BIT] && top <= line && bottom >= line;
    assign last    = tbl_idx == 4'(OBJ_ENTRIES - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            tbl_idx   <= '0;
            line      <= '0;
            job.start <= 1'b0;
        end else if (hstart) begin
            state     <= READ;          // Restart from entry 0
            tbl_idx   <= '0;
            line      <= vline;
            job.start <= 1'b0;
        end else begin
            case (state)
                READ:   state <= CHECK;  // Table read is registered
                CHECK: begin
                    if (hit) begin
                        state <= LAUNCH;
                    end else if (last) begin
                        state <= DONE;
                    end else begin
                        tbl_idx <= tbl_idx + 4'd1;
                        state   <= READ;
                    end
                end
                LAUNCH: begin
                    // Previous sprite still drawing
                    if (!job.busy) begin
                        job.start <= 1'b1;
                        state     <= WAIT;
                    end
                end
                WAIT: begin
                    job.start <= 1'b0;   // Busy not yet valid here
                    if (last) begin
                        state <= DONE;
                    end else begin
                        tbl_idx <= tbl_idx + 4'd1;
                        state   <= READ;
                    end
                end
                default: state <= state; // IDLE and DONE wait for hstart
            endcase
        end
    end

    // Job fields, loaded once per hit and held through start
    always_ff @(posedge clk) begin
        if (state == CHECK && hit) begin
            job.xpos   <= w1[8:0];
            job.hflip  <= w1[OBJ_HFLIP_BIT];
            job.hzoom  <= w1[OBJ_ZOOM_LSB +: 5];
            job.offset <= row_ofs;
            job.bank   <= w3[3:0];
            job.prio   <= w3[OBJ_PRIO_LSB +: 2];
            job.pal    <= w3[OBJ_PAL_LSB +: 6];
        end
    end

    start_idle_a: assert property (@(posedge clk) disable iff (rst)
        job.start |-> !job.busy);

endmodule

`default_nettype wire

// File: tests/tb_obj.sv
// ROM model spans the full 20-bit space; every word at an address ending in 11 ends a sprite
`timescale 1ns/10ps
`default_nettype none

module tb_obj import obj_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int NUM_LINES    = 2 + 5 + 1;   // Warm-up, tests, flush
    localparam int LINE_CYCLES  = 1024 + 2 + OBJ_ENTRIES * OBJ_WORDS;
    localparam int CYCLE_LIMIT  = NUM_LINES * LINE_CYCLES + RESET_CYCLES + 2048;

    logic                  clk;
    logic                  rst;
    logic                  host_we;
    logic [OBJ_TBL_AW-1:0] host_addr;
    logic [15:0]           host_data;
    logic                  hstart;
    obj_line_t             vline;
    logic                  obj_cs;
    obj_rom_addr_t         obj_addr;
    obj_rom_data_t         obj_data;
    logic                  obj_ok;
    obj_xpos_t             rd_addr;
    obj_pxl_t              rd_data;

    integer        seed;                           // Stimulus and ROM contents
    integer        lat_seed;                       // ROM latency only
    obj_rom_data_t rom [1 << 20];
    logic [15:0]   tbl [OBJ_ENTRIES][OBJ_WORDS];  // Host copy of the table
    obj_pxl_t      drawn [OBJ_BUF_DEPTH];          // Image of the line being drawn
    obj_pxl_t      shown [OBJ_BUF_DEPTH];          // Image of the line being read
    string         test_names [5];
    int            pass_cnt;
    int            fail_cnt;
    int            line_errs;

    obj_top DUT (
        .clk       (clk),
        .rst       (rst),
        .host_we   (host_we),
        .host_addr (host_addr),
        .host_data (host_data),
        .hstart    (hstart),
        .vline     (vline),
        .obj_cs    (obj_cs),
        .obj_addr  (obj_addr),
        .obj_data  (obj_data),
        .obj_ok    (obj_ok),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rnd(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // Nibble is 15 one time in four; end nibbles forced at addresses ending in 11
    task automatic fill_rom();
        int            a;
        int            k;
        logic [31:0]   r;
        obj_rom_data_t w;
        for (a = 0; a < (1 << 20); a++) begin
            r = $random(seed);
            for (k = 0; k < 4; k++) begin
                w[4*k +: 4] = (r[8*k +: 2] == 2'd0) ? 4'hf : 4'(r[8*k+2 +: 4] % 15);
            end
            if (a[1:0] == 2'b11) begin
                w[15:12] = 4'hf;
                w[3:0]   = 4'hf;
            end
            rom[a] = w;
        end
    endtask

    // Mode 0 plain, 1 flipped, 2 zoomed, 3 random ranges clustered for overlap
    task automatic make_table(input int mode, input obj_line_t line);
        int        e;
        logic      en;
        logic      flip;
        obj_line_t top;
        obj_line_t bot;
        obj_xpos_t x;
        obj_zoom_t zoom;
        for (e = 0; e < OBJ_ENTRIES; e++) begin
            en   = rnd(3) != 0;
            top  = line - obj_line_t'(rnd(30));   // Always covers the line
            bot  = line + obj_line_t'(rnd(30));
            x    = obj_xpos_t'(rnd(OBJ_BUF_DEPTH));
            flip = mode == 1;
            zoom = '0;
            if (mode >= 2) begin
                flip = rnd(2) == 1;
                zoom = obj_zoom_t'(rnd(32));
            end
            if (mode == 3) begin
                en  = rnd(2) == 0;
                top = line - obj_line_t'(40) + obj_line_t'(rnd(80));
                bot = top + obj_line_t'(rnd(48));  // May also wrap below top
                x   = obj_xpos_t'(200 + rnd(48));
            end
            tbl[e][0] = {bot, top};
            tbl[e][1] = {en, zoom, flip, x};
            tbl[e][2] = 16'(rnd(65536));          // Base offset
            tbl[e][3] = 16'(rnd(65536));          // Pitch, palette, priority, bank
        end
    endtask

    task automatic load_table();
        int e;
        int w;
        int a;
        for (e = 0; e < OBJ_ENTRIES; e++) begin
            for (w = 0; w < OBJ_WORDS; w++) begin
                a         = e * OBJ_WORDS + w;
                host_we   = 1'b1;
                host_addr = a[OBJ_TBL_AW-1:0];
                host_data = tbl[e][w];
                @(posedge clk);
                #1;
            end
        end
        host_we = 1'b0;
    endtask

    // Reference line, entries in table order so later ones overwrite
    task automatic build_line(input obj_line_t line);
        int            e;
        int            n;
        int            p;
        logic [15:0]   w1;
        logic [15:0]   w3;
        obj_line_t     top;
        obj_line_t     row;
        obj_ofs_t      ofs;
        obj_xpos_t     col;
        logic [6:0]    acc;
        logic [7:0]    sum;
        obj_rom_data_t word;
        logic [3:0]    pix;
        obj_zoom_t     zoom;
        logic          flip;
        for (p = 0; p < OBJ_BUF_DEPTH; p++) drawn[p] = OBJ_BLANK;
        for (e = 0; e < OBJ_ENTRIES; e++) begin
            w1  = tbl[e][1];
            w3  = tbl[e][3];
            top = tbl[e][0][7:0];
            if (!w1[OBJ_EN_BIT] || line < top || line > tbl[e][0][15:8]) continue;
            row  = line - top;
            ofs  = obj_ofs_t'(int'(tbl[e][2]) + int'(row) * int'(w3[OBJ_PITCH_LSB +: 4]));
            col  = w1[8:0];
            flip = w1[OBJ_HFLIP_BIT];
            zoom = w1[OBJ_ZOOM_LSB +: 5];
            acc  = 7'(zoom * 4);
            for (n = 0; n < 8; n++) begin        // ROM layout bounds a sprite to 4 words
                word = rom[{w3[3:0], ofs}];
                for (p = 0; p < 4; p++) begin
                    pix = flip ? word[4*p +: 4] : word[12-4*p +: 4];
                    sum = acc + zoom;
                    acc = sum[6:0];
                    if (!sum[7]) begin           // Carry drops the pixel
                        if (pix != OBJ_TRANSP) begin
                            drawn[col] = {w3[OBJ_PRIO_LSB +: 2], w3[OBJ_PAL_LSB +: 6], pix};
                        end
                        col = col + 9'd1;
                    end
                end
                if (pix == OBJ_TRANSP) break;    // Last pixel in drawing order
                ofs = flip ? ofs - 16'd1 : ofs + 16'd1;
            end
        end
    endtask

    task automatic check_pxl(input string name, input obj_xpos_t col,
                             input obj_pxl_t exp_v, input obj_pxl_t act);
        if (act !== exp_v) begin
            $display("FAILED %s col %0d expected %h actual %h", name, col, exp_v, act);
            fail_cnt++;
            line_errs++;
        end else begin
            pass_cnt++;
        end
    endtask

    // One hstart, then two read passes of the previous line; second must be blank
    task automatic run_line(input obj_line_t line, input string name, input logic check);
        int       i;
        obj_pxl_t exp_v;
        line_errs = 0;
        hstart    = 1'b1;
        vline     = line;
        @(posedge clk);
        #1;
        hstart = 1'b0;
        for (i = 0; i <= 2 * OBJ_BUF_DEPTH; i++) begin
            if (i < 2 * OBJ_BUF_DEPTH) rd_addr = obj_xpos_t'(i);
            if (check && i > 0) begin
                exp_v = (i - 1 < OBJ_BUF_DEPTH) ? shown[obj_xpos_t'(i - 1)] : OBJ_BLANK;
                check_pxl(name, obj_xpos_t'(i - 1), exp_v, rd_data);
            end
            @(posedge clk);
            #1;
        end
        if (check) begin
            $display("test %-10s %0d reads, %0d mismatches", name, 2 * OBJ_BUF_DEPTH, line_errs);
        end
    endtask

    // ROM answers 1 to 4 cycles after a request, holds obj_ok until obj_cs drops
    initial begin : rom_model
        int   wait_cnt;
        logic pending;
        wait_cnt = 0;
        pending  = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!obj_cs) begin
                obj_ok  = 1'b0;
                pending = 1'b0;
            end else if (!obj_ok) begin
                if (!pending) begin
                    pending  = 1'b1;
                    wait_cnt = 1 + (($random(lat_seed) & 32'h7fff_ffff) % 4);
                end else begin
                    wait_cnt--;
                end
                if (pending && wait_cnt == 0) begin
                    obj_ok   = 1'b1;
                    obj_data = rom[obj_addr];
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the line sequence did not complete", cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        int        t;
        obj_line_t line;
        string     shown_name;
        seed          = 32'ha85e;
        lat_seed      = 32'ha85e;
        rst           = 1'b1;
        host_we       = 1'b0;
        host_addr     = '0;
        host_data     = '0;
        hstart        = 1'b0;
        vline         = '0;
        obj_data      = '0;
        obj_ok        = 1'b0;
        rd_addr       = '0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        test_names[0] = "unflipped";
        test_names[1] = "flipped";
        test_names[2] = "zoom";
        test_names[3] = "selection";
        test_names[4] = "latency";
        line          = '0;
        fill_rom();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // Two unchecked lines clear both halves
        run_line(8'd0, "warmup", 1'b0);
        run_line(8'd0, "warmup", 1'b0);
        for (int p = 0; p < OBJ_BUF_DEPTH; p++) shown[p] = OBJ_BLANK;
        shown_name = "blank";

        for (t = 0; t < 5; t++) begin
            // Last test redraws the previous table under fresh ROM latencies
            if (t < 4) begin
                line = obj_line_t'(30 + rnd(190));
                make_table(t, line);
            end
            load_table();
            build_line(line);
            run_line(line, shown_name, 1'b1);
            shown      = drawn;
            shown_name = test_names[t];
        end
        run_line(8'd0, shown_name, 1'b1);         // Flush out the last image

        $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
